// File: project.f
common/chitchat_pkg.sv
source/crc16.sv
chitchat/chitchat_tx.sv
chitchat/chitchat_rx.sv
source/chitchat_link.sv
dv/chitchat_tb.sv

// File: Makefile
# Verilator build and run for the chassis status link

VERILATOR   ?= verilator
TOP         ?= chitchat_tb
FILELIST    ?= project.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
EXTRA_FLAGS ?= -j 0

VFLAGS := --binary --timing --assert --top-module $(TOP) $(EXTRA_FLAGS)
SRCS   := $(shell grep -v '^+' $(FILELIST))
SIM    := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "FAIL: no result in $(LOG)"; exit 1; }
	@echo "PASS"

check:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/chitchat_tb.sv
/* Testbench for the status link with xorshift field stimulus, a channel with
   fault injection, a frame-level receiver model, checks and a watchdog */

`default_nettype none

module chitchat_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import chitchat_pkg::*;

   localparam int frame_words = 12;
   localparam int link_up_cnt = 4;
   localparam int n_frames    = 200;
   localparam int clk_ns      = 10;
   // Test length plus margin makes 300 frame periods in all
   localparam int watchdog_ns = (n_frames + 100) * frame_words * clk_ns;

   // Channel fault kinds with at most one per frame
   localparam int f_none = 0;
   localparam int f_flip = 1;
   localparam int f_cat  = 2;
   localparam int f_seq  = 3;
   localparam int f_nok  = 4;

   typedef struct packed {
      logic [2:0]  gw;
      logic [2:0]  loc;
      logic [31:0] rev;
      logic [31:0] d0;
      logic [31:0] d1;
      logic [15:0] fc;
      logic [15:0] lb;
   } frame_rec_t;

   logic        clk;
   logic        reset;
   logic [2:0]  tx_gateware_type;
   logic [2:0]  tx_location;
   logic [31:0] tx_rev_id;
   logic [31:0] tx_data0;
   logic [31:0] tx_data1;
   logic [15:0] gtx_tx_d;
   logic        gtx_tx_k;
   logic [15:0] gtx_rx_d;
   logic        gtx_rx_k;
   logic [15:0] local_frame_counter;
   logic        tx_frame_strobe;
   logic [2:0]  ccrx_fault;
   logic [15:0] ccrx_fault_cnt;
   logic        ccrx_los;
   logic        ccrx_frame_drop;
   logic        rx_valid;
   logic [3:0]  rx_protocol_ver;
   logic [2:0]  rx_gateware_type;
   logic [2:0]  rx_location;
   logic [31:0] rx_rev_id;
   logic [31:0] rx_data0;
   logic [31:0] rx_data1;
   logic [15:0] rx_frame_counter;
   logic [15:0] rx_loopback_frame_counter;

   chitchat_link #(
      .frame_words (frame_words),
      .link_up_cnt (link_up_cnt)
   ) u_dut (.*);

   always #(clk_ns / 2) clk = ~clk;

   // Stimulus and channel state
   logic [31:0] rng;
   frame_rec_t  sent_q[$];
   frame_rec_t  rec;
   frame_rec_t  exp_rec;
   int          frame_num;
   int          tx_idx;
   int          kind;
   int          hit_word;
   logic [15:0] hit_mask;
   logic [3:0]  bad_cat;
   logic [15:0] chan_crc;
   logic [15:0] word;
   logic        k;
   logic [15:0] stage_d;
   logic        stage_k;
   logic [15:0] rx_fc_prev;
   // Receiver model state
   logic [15:0] rx_words[0:10];
   logic        frame_k;
   int          link_cnt_m;
   logic [2:0]  latch_m;
   logic [15:0] fault_cnt_m;
   logic        los_m;
   logic [15:0] prev_fc_m;
   logic        exp_valid;
   logic        exp_drop;
   // Bookkeeping
   int          check_wait;
   int          frames_done;
   int          valid_seen;
   int          kind_seen[5];
   int          checks;
   int          errors;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // CCITT CRC with one word folded into c MSB first
   function automatic logic [15:0] crc_word(input logic [15:0] c, input logic [15:0] w);
      logic [15:0] r;
      r = c;
      for (int b = 15; b >= 0; b--) begin
         if (r[15] ^ w[b]) r = (r << 1) ^ cc_crc_poly;
         else r = r << 1;
      end
      return r;
   endfunction

   task automatic expect_eq(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic draw_fields();
      rng = xorshift32(rng);
      tx_gateware_type = rng[2:0];
      tx_location      = rng[5:3];
      rng = xorshift32(rng);
      tx_rev_id = rng;
      rng = xorshift32(rng);
      tx_data0 = rng;
      rng = xorshift32(rng);
      tx_data1 = rng;
   endtask

   // First eight frames stay clean so the link comes up
   task automatic pick_fault();
      rng  = xorshift32(rng);
      kind = f_none;
      if (frame_num > 8) begin
         case (rng[3:0])
            4'd0, 4'd1: kind = f_flip;
            4'd2:       kind = f_cat;
            4'd3:       kind = f_seq;
            4'd4:       kind = f_nok;
            default:    kind = f_none;
         endcase
      end
      hit_word = 1 + int'(rng[11:8]) % cc_data_words;
      hit_mask = 16'h0001 << rng[15:12];
      bad_cat  = rng[19:16];
      if (bad_cat == cc_protocol_cat) bad_cat = ~bad_cat;
      kind_seen[kind]++;
   endtask

   // ---------------------------------------------------------------------
   // Receiver rules applied to one frame as it left the channel
   // ---------------------------------------------------------------------
   task automatic predict_frame();
      logic [15:0] c;
      logic [2:0]  f;
      c = 16'h0000;
      for (int i = 0; i <= cc_data_words; i++) c = crc_word(c, rx_words[i]);
      exp_valid = 1'b0;
      exp_drop  = 1'b0;
      if (!frame_k) begin
         // Without a comma sync is lost and the link count restarts
         los_m      = 1'b1;
         link_cnt_m = 0;
      end else begin
         f[0] = rx_words[0][15:12] != cc_protocol_cat;
         f[1] = c != 16'h0000;
         // Sequence skipped while a fault is latched or sync was lost
         f[2] = latch_m == 3'b000 && !los_m && rx_words[8] != prev_fc_m + 16'd1;
         prev_fc_m = rx_words[8];
         los_m     = 1'b0;
         if (f != 3'b000) begin
            exp_drop = 1'b1;
            if (link_cnt_m != 0) begin
               latch_m     = f;
               fault_cnt_m = fault_cnt_m + 16'd1;
            end
            link_cnt_m = 0;
         end else begin
            exp_valid = link_cnt_m == link_up_cnt;
            exp_drop  = !exp_valid;
            if (!exp_valid) link_cnt_m++;
            latch_m = 3'b000;
         end
      end
   endtask

   task automatic check_decision();
      expect_eq("rx_valid", 32'(rx_valid), 32'(exp_valid));
      expect_eq("ccrx_frame_drop", 32'(ccrx_frame_drop), 32'(exp_drop));
      expect_eq("ccrx_los", 32'(ccrx_los), 32'(los_m));
      expect_eq("ccrx_fault", 32'(ccrx_fault), 32'(latch_m));
      expect_eq("ccrx_fault_cnt", 32'(ccrx_fault_cnt), 32'(fault_cnt_m));
      if (exp_valid) begin
         valid_seen++;
         expect_eq("rx_protocol_ver", 32'(rx_protocol_ver), 32'(cc_protocol_ver));
         expect_eq("rx_gateware_type", 32'(rx_gateware_type), 32'(exp_rec.gw));
         expect_eq("rx_location", 32'(rx_location), 32'(exp_rec.loc));
         expect_eq("rx_rev_id", rx_rev_id, exp_rec.rev);
         expect_eq("rx_data0", rx_data0, exp_rec.d0);
         expect_eq("rx_data1", rx_data1, exp_rec.d1);
         expect_eq("rx_frame_counter", 32'(rx_frame_counter), 32'(exp_rec.fc));
         expect_eq("rx_loopback_frame_counter", 32'(rx_loopback_frame_counter),
                   32'(exp_rec.lb));
      end
   endtask

   // ---------------------------------------------------------------------
   // Main sequence with all inputs driven 1 ns after the rising edge
   // ---------------------------------------------------------------------
   initial begin
      clk = 1'b0;
      reset = 1'b1;
      gtx_rx_d = '0;
      gtx_rx_k = 1'b0;
      rng = 32'd95568;
      draw_fields();
      {frame_num, check_wait, frames_done, valid_seen, checks, errors} = '0;
      kind_seen = '{default: 0};
      tx_idx = 15;
      kind = f_none;
      {stage_d, stage_k, chan_crc, rx_fc_prev} = '0;
      {link_cnt_m, latch_m, fault_cnt_m, los_m, prev_fc_m} = '0;
      repeat (2) @(posedge clk);
      #1 reset = 1'b0;
      while (frames_done < n_frames) begin
         @(posedge clk);
         #1;
         // Pulses only at a frame decision
         if (check_wait == 1) begin
            check_decision();
            frames_done++;
         end else begin
            expect_eq("pulse outside frame end", 32'({rx_valid, ccrx_frame_drop}), 32'd0);
         end
         if (check_wait > 0) check_wait--;
         // Strobe marks the cycle that carries the comma word
         expect_eq("tx_frame_strobe", 32'(tx_frame_strobe), 32'(gtx_tx_k));
         // Fields just sampled belong to this frame before new ones go out
         if (tx_frame_strobe) begin
            frame_num++;
            expect_eq("local_frame_counter", 32'(local_frame_counter), frame_num);
            rec.gw  = tx_gateware_type;
            rec.loc = tx_location;
            rec.rev = tx_rev_id;
            rec.d0  = tx_data0;
            rec.d1  = tx_data1;
            rec.fc  = 16'(frame_num);
            rec.lb  = rx_fc_prev;
            sent_q.push_back(rec);
            draw_fields();
         end
         // Channel with fault injection
         if (gtx_tx_k) begin
            // One comma every frame period
            if (frame_num > 1) expect_eq("comma spacing", tx_idx + 1, frame_words);
            tx_idx = 0;
            pick_fault();
         end else if (tx_idx < 15) begin
            tx_idx++;
         end
         word = gtx_tx_d;
         k    = gtx_tx_k;
         case (kind)
            f_flip:  if (tx_idx == hit_word) word = word ^ hit_mask;
            f_cat:   if (tx_idx == 0) word[15:12] = bad_cat;
            f_seq:   if (tx_idx == 8) word = word ^ hit_mask;
            f_nok:   if (tx_idx == 0) k = 1'b0;
            default: ;
         endcase
         // Re-sealed CRC leaves only the category or sequence fault
         if ((kind == f_cat || kind == f_seq) && tx_idx == cc_data_words) word = chan_crc;
         if (tx_idx < cc_data_words) begin
            chan_crc = crc_word(tx_idx == 0 ? 16'h0000 : chan_crc, word);
         end
         if (tx_idx == 0) frame_k = k;
         if (tx_idx <= cc_data_words) rx_words[tx_idx] = word;
         // CRC word leaves now and the decision comes three clocks on
         if (tx_idx == cc_data_words) begin
            exp_rec = sent_q.pop_front();
            predict_frame();
            check_wait = 3;
         end
         gtx_rx_d   = stage_d;
         gtx_rx_k   = stage_k;
         stage_d    = word;
         stage_k    = k;
         rx_fc_prev = rx_frame_counter;
      end
      for (int i = f_flip; i <= f_nok; i++) begin
         assert (kind_seen[i] > 0) else begin
            errors++;
            $display("Fault kind %0d was never injected", i);
         end
      end
      assert (valid_seen > 0) else begin
         errors++;
         $display("The link never delivered a frame");
      end
      $display("Frames: %0d, checks: %0d, errors: %0d", frames_done, checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(watchdog_ns);
      $display("Watchdog: run did not finish within %0d ns", watchdog_ns);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/chitchat_link.sv
/* Status link top: transmitter and receiver, with the received frame
   counter looped back into the transmitted frames */

`default_nettype none

module chitchat_link #(
   parameter int frame_words = 12,
   parameter int link_up_cnt = 4
) (
   input  logic                            clk,
   input  logic                            reset,
   // Status fields to send
   input  logic [2:0]                      tx_gateware_type,
   input  logic [2:0]                      tx_location,
   input  logic [31:0]                     tx_rev_id,
   input  logic [31:0]                     tx_data0,
   input  logic [31:0]                     tx_data1,
   // Transceiver side
   output logic [chitchat_pkg::cc_word_w-1:0] gtx_tx_d,
   output logic                            gtx_tx_k,
   input  logic [chitchat_pkg::cc_word_w-1:0] gtx_rx_d,
   input  logic                            gtx_rx_k,
   // Transmit frame status
   output logic [15:0]                     local_frame_counter,
   output logic                            tx_frame_strobe,
   // Receive status and fields
   output logic [2:0]                      ccrx_fault,
   output logic [15:0]                     ccrx_fault_cnt,
   output logic                            ccrx_los,
   output logic                            ccrx_frame_drop,
   output logic                            rx_valid,
   output logic [3:0]                      rx_protocol_ver,
   output logic [2:0]                      rx_gateware_type,
   output logic [2:0]                      rx_location,
   output logic [31:0]                     rx_rev_id,
   output logic [31:0]                     rx_data0,
   output logic [31:0]                     rx_data1,
   output logic [15:0]                     rx_frame_counter,
   output logic [15:0]                     rx_loopback_frame_counter
);

   // Far end sees its own counter come back in the loopback field,
   // so local_frame_counter minus rx_loopback_frame_counter gives round trip
   chitchat_tx #(
      .frame_words (frame_words)
   ) u_tx (
      .clk                    (clk),
      .reset                  (reset),
      .tx_gateware_type       (tx_gateware_type),
      .tx_location            (tx_location),
      .tx_rev_id              (tx_rev_id),
      .tx_data0               (tx_data0),
      .tx_data1               (tx_data1),
      .loopback_frame_counter (rx_frame_counter),
      .gtx_tx_d               (gtx_tx_d),
      .gtx_tx_k               (gtx_tx_k),
      .tx_frame_strobe        (tx_frame_strobe),
      .local_frame_counter    (local_frame_counter)
   );

   chitchat_rx #(
      .link_up_cnt (link_up_cnt)
   ) u_rx (
      .clk                       (clk),
      .reset                     (reset),
      .gtx_rx_d                  (gtx_rx_d),
      .gtx_rx_k                  (gtx_rx_k),
      .ccrx_fault                (ccrx_fault),
      .ccrx_fault_cnt            (ccrx_fault_cnt),
      .ccrx_los                  (ccrx_los),
      .ccrx_frame_drop           (ccrx_frame_drop),
      .rx_valid                  (rx_valid),
      .rx_protocol_ver           (rx_protocol_ver),
      .rx_gateware_type          (rx_gateware_type),
      .rx_location               (rx_location),
      .rx_rev_id                 (rx_rev_id),
      .rx_data0                  (rx_data0),
      .rx_data1                  (rx_data1),
      .rx_frame_counter          (rx_frame_counter),
      .rx_loopback_frame_counter (rx_loopback_frame_counter)
   );

endmodule

`default_nettype wire

// File: chitchat/chitchat_rx.sv
/* Frame receiver of the status link: word timing from the comma, field
   unpacking, CRC, category and sequence checks, link-up and fault tracking */

`default_nettype none

module chitchat_rx #(
   parameter int link_up_cnt = 4
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [chitchat_pkg::cc_word_w-1:0] gtx_rx_d,
   input  logic                            gtx_rx_k,
   output logic [2:0]                      ccrx_fault,
   output logic [15:0]                     ccrx_fault_cnt,
   output logic                            ccrx_los,
   output logic                            ccrx_frame_drop,
   output logic                            rx_valid,
   output logic [3:0]                      rx_protocol_ver,
   output logic [2:0]                      rx_gateware_type,
   output logic [2:0]                      rx_location,
   output logic [31:0]                     rx_rev_id,
   output logic [31:0]                     rx_data0,
   output logic [31:0]                     rx_data1,
   output logic [15:0]                     rx_frame_counter,
   output logic [15:0]                     rx_loopback_frame_counter
);
   import chitchat_pkg::*;

   localparam int wc_w = $clog2(cc_los_words + 1);
   localparam int lc_w = $clog2(link_up_cnt + 1);

   // ---------------------------------------------------------------------
   // Timing generator
   // ---------------------------------------------------------------------
   // Count value k means word k+1 is on the input, word k in gtx_dd
   logic [wc_w-1:0]      word_count;
   logic [cc_word_w-1:0] gtx_dd;
   logic                 timeout;
   logic                 last;

   // Saturates at the LOS limit until the next comma
   assign timeout = word_count == wc_w'(cc_los_words);

   always_ff @(posedge clk) begin
      if (reset) begin
         word_count <= '0;
      end else if (gtx_rx_k) begin
         word_count <= '0;
      end else if (!timeout) begin
         word_count <= word_count + 1'b1;
      end
   end

   // CRC restarts on the comma word
   logic [15:0] crc_rx;

   crc16 u_crc (
      .clk     (clk),
      .reset   (reset),
      .restart (gtx_rx_k),
      .din     (gtx_rx_d),
      .crc     (crc_rx)
   );

   // ---------------------------------------------------------------------
   // Field unpacking and per-frame checks
   // ---------------------------------------------------------------------
   logic        wrong_prot;
   logic        wrong_frame;
   logic [15:0] next_frame_counter;

   always_ff @(posedge clk) begin
      if (reset) begin
         gtx_dd                    <= '0;
         last                      <= 1'b0;
         next_frame_counter        <= '0;
         wrong_prot                <= 1'b0;
         wrong_frame               <= 1'b0;
         rx_protocol_ver           <= '0;
         rx_gateware_type          <= '0;
         rx_location               <= '0;
         rx_rev_id                 <= '0;
         rx_data0                  <= '0;
         rx_data1                  <= '0;
         rx_frame_counter          <= '0;
         rx_loopback_frame_counter <= '0;
      end else begin
         gtx_dd             <= gtx_rx_d;
         next_frame_counter <= rx_frame_counter + 16'd1;
         // CRC word is on the input while the count sits at 9
         last               <= word_count == wc_w'(cc_data_words - 1);

         // Checks from the previous frame end at the comma
         if (gtx_rx_k) begin
            wrong_prot  <= 1'b0;
            wrong_frame <= 1'b0;
         end

         // Word 0 is decoded one clock late, word 1 is live
         if (word_count == wc_w'(0)) begin
            rx_protocol_ver  <= gtx_dd[11:8];
            wrong_prot       <= gtx_dd[15:12] != cc_protocol_cat;
            rx_gateware_type <= gtx_rx_d[15:13];
            rx_location      <= gtx_rx_d[12:10];
         end

         // 32-bit fields, high word in gtx_dd
         if (word_count == wc_w'(2)) rx_rev_id <= {gtx_dd, gtx_rx_d};
         if (word_count == wc_w'(4)) rx_data0  <= {gtx_dd, gtx_rx_d};
         if (word_count == wc_w'(6)) rx_data1  <= {gtx_dd, gtx_rx_d};

         // Frame counter, sequence not checked after a bad frame or lost sync
         if (word_count == wc_w'(7)) begin
            rx_frame_counter <= gtx_rx_d;
            if (ccrx_fault == '0 && !ccrx_los)
               wrong_frame <= gtx_rx_d != next_frame_counter;
         end

         if (word_count == wc_w'(8)) rx_loopback_frame_counter <= gtx_rx_d;
      end
   end

   // ---------------------------------------------------------------------
   // Link-up tracking, fault latch and counters
   // ---------------------------------------------------------------------
   logic [lc_w-1:0] link_cnt;
   logic            link_up;
   logic            crc_fault;
   logic [2:0]      faults;

   assign link_up   = link_cnt == lc_w'(link_up_cnt);
   // Remainder over all eleven words is zero for a good frame
   assign crc_fault = last & (crc_rx != 16'h0000);
   assign faults    = {wrong_frame, crc_fault, wrong_prot};

   always_ff @(posedge clk) begin
      if (reset) begin
         link_cnt        <= '0;
         rx_valid        <= 1'b0;
         ccrx_frame_drop <= 1'b0;
         ccrx_los        <= 1'b0;
         ccrx_fault      <= '0;
         ccrx_fault_cnt  <= '0;
      end else begin
         rx_valid        <= 1'b0;
         ccrx_frame_drop <= 1'b0;

         // Decide at frame end, or keep deciding while sync is lost
         if (last || timeout) begin
            ccrx_los <= timeout;
            if (faults != '0 || timeout) begin
               link_cnt        <= '0;
               ccrx_frame_drop <= last;
            end else begin
               link_cnt        <= link_cnt + lc_w'(!link_up);
               rx_valid        <= link_up;
               ccrx_frame_drop <= !link_up;
               ccrx_fault      <= '0;
            end
         end

         // Faults only count once some clean frames have been seen
         if (last && link_cnt != '0 && faults != '0) begin
            ccrx_fault     <= faults;
            ccrx_fault_cnt <= ccrx_fault_cnt + 16'd1;
         end
      end
   end

   // A frame is either delivered or dropped, never both
   a_valid_drop: assert property (@(posedge clk) disable iff (reset)
      !(rx_valid && ccrx_frame_drop));

   // Delivered frames carry no latched fault
   a_valid_fault: assert property (@(posedge clk) disable iff (reset)
      rx_valid |-> ccrx_fault == '0);

endmodule

`default_nettype wire

// File: chitchat/chitchat_tx.sv
/* Frame generator of the status link. Samples the status fields once per
   frame and emits the comma word, field words, CRC word and idle words */

`default_nettype none

module chitchat_tx #(
   parameter int frame_words = 12
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [2:0]                      tx_gateware_type,
   input  logic [2:0]                      tx_location,
   input  logic [31:0]                     tx_rev_id,
   input  logic [31:0]                     tx_data0,
   input  logic [31:0]                     tx_data1,
   input  logic [15:0]                     loopback_frame_counter,
   output logic [chitchat_pkg::cc_word_w-1:0] gtx_tx_d,
   output logic                            gtx_tx_k,
   output logic                            tx_frame_strobe,
   output logic [15:0]                     local_frame_counter
);
   import chitchat_pkg::*;

   // Frame period of 11 to 14 words keeps the counter at 4 bits
   if (frame_words < cc_data_words + 1 || frame_words > 14) begin : g_bad_period
      $error("chitchat_tx: frame_words out of range");
   end

   logic [3:0]           word_cnt;
   logic [cc_word_w-1:0] next_word;
   logic [15:0]          crc;

   // Field copy held for the whole frame
   logic [2:0]  gw_type_q;
   logic [2:0]  location_q;
   logic [31:0] rev_id_q;
   logic [31:0] data0_q;
   logic [31:0] data1_q;
   logic [15:0] loopback_q;

   // ---------------------------------------------------------------------
   // Word select
   // ---------------------------------------------------------------------
   always_comb begin
      case (word_cnt)
         4'd0:    next_word = {cc_protocol_cat, cc_protocol_ver, cc_comma};
         4'd1:    next_word = {gw_type_q, location_q, 10'b0};
         4'd2:    next_word = rev_id_q[31:16];
         4'd3:    next_word = rev_id_q[15:0];
         4'd4:    next_word = data0_q[31:16];
         4'd5:    next_word = data0_q[15:0];
         4'd6:    next_word = data1_q[31:16];
         4'd7:    next_word = data1_q[15:0];
         4'd8:    next_word = local_frame_counter;
         4'd9:    next_word = loopback_q;
         // CRC over words 0 to 9 already folded in
         4'(cc_data_words): next_word = crc;
         // Idle fill up to the frame period
         default: next_word = '0;
      endcase
   end

   // CRC sees each word as it goes out and restarts on word 0
   crc16 u_crc (
      .clk     (clk),
      .reset   (reset),
      .restart (word_cnt == 4'd0),
      .din     (next_word),
      .crc     (crc)
   );

   // ---------------------------------------------------------------------
   // Output register and frame timing
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         word_cnt            <= '0;
         gtx_tx_d            <= '0;
         gtx_tx_k            <= 1'b0;
         tx_frame_strobe     <= 1'b0;
         local_frame_counter <= '0;
         gw_type_q           <= '0;
         location_q          <= '0;
         rev_id_q            <= '0;
         data0_q             <= '0;
         data1_q             <= '0;
         loopback_q          <= '0;
      end else begin
         gtx_tx_d        <= next_word;
         gtx_tx_k        <= word_cnt == 4'd0;
         tx_frame_strobe <= word_cnt == 4'd0;
         word_cnt        <= (word_cnt == 4'(frame_words - 1)) ? 4'd0 : word_cnt + 4'd1;
         // Sample on the clock that emits word 0
         if (word_cnt == 4'd0) begin
            gw_type_q           <= tx_gateware_type;
            location_q          <= tx_location;
            rev_id_q            <= tx_rev_id;
            data0_q             <= tx_data0;
            data1_q             <= tx_data1;
            loopback_q          <= loopback_frame_counter;
            local_frame_counter <= local_frame_counter + 16'd1;
         end
      end
   end

   // Comma only on word 0 with the K28.5 byte in place
   a_k_word0: assert property (@(posedge clk) disable iff (reset)
      gtx_tx_k |-> ($past(word_cnt) == 4'd0) && (gtx_tx_d[7:0] == cc_comma));

endmodule

`default_nettype wire

// File: source/crc16.sv
/* Word-wide CRC-16 engine, one word folded in per clock */

`default_nettype none

module crc16 (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            restart,
   input  logic [chitchat_pkg::cc_word_w-1:0] din,
   output logic [15:0]                     crc
);
   import chitchat_pkg::*;

   // Shift one word through the CRC, MSB first
   function automatic logic [15:0] crc_step(input logic [15:0] seed,
                                            input logic [cc_word_w-1:0] word);
      logic [15:0] r;
      logic        fb;
      r = seed;
      for (int i = cc_word_w - 1; i >= 0; i--) begin
         fb = r[15] ^ word[i];
         r  = {r[14:0], 1'b0} ^ (fb ? cc_crc_poly : 16'h0000);
      end
      return r;
   endfunction

   // Restart seeds from zero with the current word included,
   // so the first word of a frame is never lost
   always_ff @(posedge clk) begin
      if (reset) begin
         crc <= '0;
      end else if (restart) begin
         crc <= crc_step(16'h0000, din);
      end else begin
         crc <= crc_step(crc, din);
      end
   end

endmodule

`default_nettype wire

// File: common/chitchat_pkg.sv
/* Constants and field widths of the chassis status link.
   Frame layout, comma marker, CRC polynomial and sync timing. */

`default_nettype none

package chitchat_pkg;

   // ---------------------------------------------------------------------
   // Link word and frame shape
   // ---------------------------------------------------------------------

   // Width of one parallel transceiver word
   localparam int cc_word_w = 16;

   // Words 0 to 9 carry data, word 10 carries the CRC
   localparam int cc_data_words = 10;

   // Clocks without a comma before sync is declared lost
   localparam int cc_los_words = 15;

   // ---------------------------------------------------------------------
   // Word 0 contents
   // ---------------------------------------------------------------------

   // Protocol category, bits 15 to 12
   localparam logic [3:0] cc_protocol_cat = 4'h5;

   // Protocol version, bits 11 to 8
   localparam logic [3:0] cc_protocol_ver = 4'h1;

   // K28.5 comma in the low byte, sent with the K flag
   localparam logic [7:0] cc_comma = 8'hBC;

   // CRC-16 CCITT, zero start, no final inversion
   localparam logic [15:0] cc_crc_poly = 16'h1021;

endpackage

`default_nettype wire
